// ==== common/shaPkg.sv ====
/*
 * SHA-256 shared package
 * word, byte, block and digest types, algorithm sizes and mixing functions
 */
package shaPkg;

    localparam int NumRounds    = 64;
    localparam int NumHashWords = 8;
    localparam int BlockWords   = 16;
    localparam int LengthBits   = 64;

    typedef logic [31:0]  wordT;
    typedef logic [7:0]   byteT;
    typedef logic [511:0] blockT;
    typedef wordT [NumHashWords-1:0] digestT;  // index 0 holds H0

    // ----------------------------------------
    // rotate and mix steps

    function automatic wordT rotr(wordT x, int unsigned n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic wordT smallSigma0(wordT x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic wordT smallSigma1(wordT x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

    function automatic wordT bigSigma0(wordT x);
        return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
    endfunction

    function automatic wordT bigSigma1(wordT x);
        return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endfunction

    function automatic wordT choose(wordT x, wordT y, wordT z);
        return (x & y) ^ (~x & z);
    endfunction

    function automatic wordT majority(wordT x, wordT y, wordT z);
        return (x & y) ^ (y & z) ^ (x & z);
    endfunction

endpackage

// ==== loader/memFetch.sv ====
/*
 * sequential reader for a synchronous memory
 * returns each word with its index after the one-cycle read latency
 */
module memFetch #(
    parameter int  Depth = 8,
    parameter type wordT = shaPkg::wordT
) (
    input  logic                       clk,
    input  logic                       resetSHA,
    input  logic                       start,
    input  logic [$clog2(Depth + 1)-1:0] count,
    output logic [$clog2(Depth)-1:0]   address,
    output logic                       enable,
    input  wordT                       data,
    output wordT                       fetchData,
    output logic [$clog2(Depth)-1:0]   fetchIndex,
    output logic                       fetchValid,
    output logic                       fetchDone
);
    localparam int AddrW  = $clog2(Depth);
    localparam int CountW = $clog2(Depth + 1);

    logic             lastAddr;
    logic             pendValid;   // memory is returning data this cycle
    logic             pendLast;
    logic [AddrW-1:0] pendIndex;

    assign lastAddr = (CountW'(address) + CountW'(1) == count);

    always_ff @(posedge clk) begin
        if (resetSHA) begin
            address    <= '0;
            enable     <= 1'b0;
            pendValid  <= 1'b0;
            pendLast   <= 1'b0;
            fetchValid <= 1'b0;
            fetchDone  <= 1'b0;
        end else begin
            pendValid  <= enable;
            pendLast   <= enable && lastAddr;
            fetchValid <= pendValid;
            if (start) begin
                address   <= '0;
                enable    <= (count != '0);
                fetchDone <= (count == '0);  // nothing to read
            end else begin
                if (enable) begin
                    address <= address + 1'b1;
                    if (lastAddr)
                        enable <= 1'b0;
                end
                if (pendValid && pendLast)
                    fetchDone <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        pendIndex  <= address;
        fetchIndex <= pendIndex;
        fetchData  <= data;
    end

endmodule

// ==== loader/padBlock.sv ====
/*
 * message padding into one 512-bit block
 * places bytes big-endian, adds the 0x80 marker and the bit length
 */
module padBlock #(
    parameter int MaxMsgBytes = 55
) (
    input  logic                               clk,
    input  logic                               resetSHA,
    input  logic                               go,
    input  logic [$clog2(MaxMsgBytes + 1)-1:0] msgLength,
    output logic                               msgStart,
    output logic [$clog2(MaxMsgBytes + 1)-1:0] msgCount,
    input  shaPkg::byteT                       fetchData,
    input  logic [$clog2(MaxMsgBytes)-1:0]     fetchIndex,
    input  logic                               fetchValid,
    input  logic                               msgDone,
    input  logic                               hashDone,
    output shaPkg::blockT                      blockOut,
    output logic                               blockReady
);
    import shaPkg::*;

    localparam int BlockBits = $bits(blockT);

    logic busy;
    logic accept;
    logic padNow;
    logic [$clog2(MaxMsgBytes + 1)-1:0] regLength;

    assign accept   = go && !busy;
    // done flags still hold the last run while msgStart is high
    assign padNow   = busy && !msgStart && msgDone && hashDone;
    assign msgCount = regLength;

    always_ff @(posedge clk) begin
        if (resetSHA) begin
            busy       <= 1'b0;
            msgStart   <= 1'b0;
            blockReady <= 1'b0;
        end else begin
            msgStart   <= accept;
            blockReady <= padNow;
            if (accept)
                busy <= 1'b1;
            else if (padNow)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            regLength <= msgLength;
            blockOut  <= '0;
        end
        if (fetchValid)
            blockOut[BlockBits-1 - 8*fetchIndex -: 8] <= fetchData;
        if (padNow) begin
            blockOut[BlockBits-1 - 8*regLength -: 8] <= 8'h80;  // marker
            blockOut[LengthBits-1:0] <= LengthBits'(regLength) << 3;
        end
    end

endmodule

// ==== rounds/msgSchedule.sv ====
/*
 * SHA-256 message schedule
 * 16-word circular window, one schedule word per request
 */
module msgSchedule (
    input  logic          clk,
    input  logic          resetSHA,
    input  shaPkg::blockT blockIn,
    input  logic          blockReady,
    input  logic          nextWord,
    output shaPkg::wordT  schedWord
);
    import shaPkg::*;

    localparam int SlotW = $clog2(BlockWords);
    localparam int BlockBits = $bits(blockT);

    wordT                         window [BlockWords];
    logic [$clog2(NumRounds)-1:0] wordIndex;
    logic [SlotW-1:0]             slot;     // also holds word t-16
    logic [SlotW-1:0]             slot2;
    logic [SlotW-1:0]             slot7;
    logic [SlotW-1:0]             slot15;
    wordT                         newWord;

    assign slot   = wordIndex[SlotW-1:0];
    assign slot2  = slot - SlotW'(2);
    assign slot7  = slot - SlotW'(7);
    assign slot15 = slot - SlotW'(15);

    assign newWord = smallSigma1(window[slot2]) + window[slot7]
                   + smallSigma0(window[slot15]) + window[slot];

    always_ff @(posedge clk) begin
        if (resetSHA)
            wordIndex <= '0;
        else if (nextWord)
            wordIndex <= wordIndex + 1'b1;  // wraps to 0 after 64 words
    end

    always_ff @(posedge clk) begin
        if (blockReady && wordIndex == '0) begin
            for (int i = 0; i < BlockWords; i++)
                window[i] <= blockIn[BlockBits-1 - 32*i -: 32];
        end else if (nextWord && wordIndex >= BlockWords) begin
            window[slot] <= newWord;  // oldest slot
        end
        if (nextWord)
            schedWord <= (wordIndex < BlockWords) ? window[slot] : newWord;
    end

endmodule

// ==== rounds/compressRound.sv ====
/*
 * SHA-256 compression, four cycles per round over a to h
 * adds the initial hash after round 63
 */
module compressRound (
    input  logic                                    clk,
    input  logic                                    resetSHA,
    input  logic                                    blockReady,
    input  shaPkg::wordT                            hashWord,
    input  logic [$clog2(shaPkg::NumHashWords)-1:0] hashIndex,
    input  logic                                    hashValid,
    output logic [$clog2(shaPkg::NumRounds)-1:0]    kAddress,
    output logic                                    kEnable,
    input  shaPkg::wordT                            kData,
    output logic                                    nextWord,
    input  shaPkg::wordT                            schedWord,
    output shaPkg::digestT                          digestOut,
    output logic                                    digestValid
);
    import shaPkg::*;

    wordT initH [NumHashWords];
    wordT a, b, c, d, e, f, g, h;
    wordT kReg;
    wordT wk;       // W + K
    wordT t1Part;   // T1 without W + K
    wordT t2;

    logic                         running;
    logic                         finalAdd;
    logic                         startRun;
    logic [1:0]                   phase;
    logic [$clog2(NumRounds)-1:0] round;

    assign startRun = blockReady && !running;
    assign kAddress = round;

    // ----------------------------------------
    // round sequencing

    always_ff @(posedge clk) begin
        if (resetSHA) begin
            running     <= 1'b0;
            finalAdd    <= 1'b0;
            phase       <= '0;
            round       <= '0;
            kEnable     <= 1'b0;
            nextWord    <= 1'b0;
            digestValid <= 1'b0;
        end else begin
            kEnable     <= 1'b0;
            nextWord    <= 1'b0;
            finalAdd    <= 1'b0;
            digestValid <= finalAdd;
            if (startRun) begin
                running  <= 1'b1;
                phase    <= '0;
                round    <= '0;
                kEnable  <= 1'b1;
                nextWord <= 1'b1;
            end else if (running) begin
                phase <= phase + 1'b1;
                if (phase == 2'd3) begin
                    if (round == NumRounds - 1) begin
                        running  <= 1'b0;
                        finalAdd <= 1'b1;
                    end else begin
                        round    <= round + 1'b1;
                        kEnable  <= 1'b1;
                        nextWord <= 1'b1;
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // datapath

    always_ff @(posedge clk) begin
        if (hashValid && !running)
            initH[hashIndex] <= hashWord;
        if (startRun) begin
            {a, b, c, d} <= {initH[0], initH[1], initH[2], initH[3]};
            {e, f, g, h} <= {initH[4], initH[5], initH[6], initH[7]};
        end else if (running) begin
            case (phase)
                2'd1: kReg <= kData;  // K returned
                2'd2: begin
                    wk     <= kReg + schedWord;
                    t1Part <= h + bigSigma1(e) + choose(e, f, g);
                    t2     <= bigSigma0(a) + majority(a, b, c);
                end
                2'd3: begin
                    a <= t1Part + wk + t2;
                    b <= a;
                    c <= b;
                    d <= c;
                    e <= d + t1Part + wk;
                    f <= e;
                    g <= f;
                    h <= g;
                end
                default: ;
            endcase
        end
        if (finalAdd) begin
            digestOut[0] <= a + initH[0];
            digestOut[1] <= b + initH[1];
            digestOut[2] <= c + initH[2];
            digestOut[3] <= d + initH[3];
            digestOut[4] <= e + initH[4];
            digestOut[5] <= f + initH[5];
            digestOut[6] <= g + initH[6];
            digestOut[7] <= h + initH[7];
        end
    end

endmodule

// ==== source/digestWriter.sv ====
/*
 * digest output writer
 * one word per cycle to addresses 0 to 7, then a finish pulse
 */
module digestWriter (
    input  logic                                    clk,
    input  logic                                    resetSHA,
    input  shaPkg::digestT                          digestIn,
    input  logic                                    digestValid,
    output logic [$clog2(shaPkg::NumHashWords)-1:0] domAddress,
    output shaPkg::wordT                            domData,
    output logic                                    domWrite,
    output logic                                    finish
);
    import shaPkg::*;

    digestT                          digest;
    logic                            writing;
    logic [$clog2(NumHashWords)-1:0] wordCount;

    always_ff @(posedge clk) begin
        if (resetSHA) begin
            writing   <= 1'b0;
            wordCount <= '0;
            domWrite  <= 1'b0;
            finish    <= 1'b0;
        end else begin
            domWrite <= writing;
            finish   <= domWrite && domAddress == NumHashWords - 1;  // after the last write
            if (digestValid) begin
                writing   <= 1'b1;
                wordCount <= '0;
            end else if (writing) begin
                wordCount <= wordCount + 1'b1;
                if (wordCount == NumHashWords - 1)
                    writing <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (digestValid)
            digest <= digestIn;
        domAddress <= wordCount;
        domData    <= digest[wordCount];
    end

endmodule

// ==== source/shaTop.sv ====
/*
 * SHA-256 single block hasher, top level
 * connects the fetchers, padding, schedule, rounds and digest writer
 */
module shaTop #(
    parameter int MaxMsgBytes = 55
) (
    input  logic                                   clk,
    input  logic                                   resetSHA,
    input  logic                                   go,
    input  logic [$clog2(MaxMsgBytes + 1)-1:0]     msgLength,
    output logic [$clog2(MaxMsgBytes)-1:0]         msgAddress,
    output logic                                   msgEnable,
    input  shaPkg::byteT                           msgData,
    output logic [$clog2(shaPkg::NumHashWords)-1:0] hAddress,
    output logic                                   hEnable,
    input  shaPkg::wordT                           hData,
    output logic [$clog2(shaPkg::NumRounds)-1:0]   kAddress,
    output logic                                   kEnable,
    input  shaPkg::wordT                           kData,
    output logic [$clog2(shaPkg::NumHashWords)-1:0] domAddress,
    output shaPkg::wordT                           domData,
    output logic                                   domWrite,
    output logic                                   finish
);
    import shaPkg::*;

    localparam int MsgLenW    = $clog2(MaxMsgBytes + 1);
    localparam int MsgAddrW   = $clog2(MaxMsgBytes);
    localparam int HashAddrW  = $clog2(NumHashWords);
    localparam int HashCountW = $clog2(NumHashWords + 1);

    logic                 fetchStart;     // starts both fetchers
    logic [MsgLenW-1:0]   msgCount;
    byteT                 msgByte;
    logic [MsgAddrW-1:0]  msgIndex;
    logic                 msgValid;
    logic                 msgDone;
    wordT                 hashWord;
    logic [HashAddrW-1:0] hashIndex;
    logic                 hashValid;
    logic                 hashDone;
    blockT                block;
    logic                 blockReady;
    logic                 nextWord;
    wordT                 schedWord;
    digestT               digest;
    logic                 digestValid;

    // ----------------------------------------
    // loaders

    memFetch #(.Depth(MaxMsgBytes), .wordT(byteT)) msgFetch (
        .clk(clk), .resetSHA(resetSHA), .start(fetchStart), .count(msgCount),
        .address(msgAddress), .enable(msgEnable), .data(msgData),
        .fetchData(msgByte), .fetchIndex(msgIndex), .fetchValid(msgValid),
        .fetchDone(msgDone)
    );

    memFetch #(.Depth(NumHashWords), .wordT(wordT)) hashFetch (
        .clk(clk), .resetSHA(resetSHA), .start(fetchStart),
        .count(HashCountW'(NumHashWords)),
        .address(hAddress), .enable(hEnable), .data(hData),
        .fetchData(hashWord), .fetchIndex(hashIndex), .fetchValid(hashValid),
        .fetchDone(hashDone)
    );

    padBlock #(.MaxMsgBytes(MaxMsgBytes)) pad (
        .clk(clk), .resetSHA(resetSHA), .go(go), .msgLength(msgLength),
        .msgStart(fetchStart), .msgCount(msgCount),
        .fetchData(msgByte), .fetchIndex(msgIndex), .fetchValid(msgValid),
        .msgDone(msgDone), .hashDone(hashDone),
        .blockOut(block), .blockReady(blockReady)
    );

    // ----------------------------------------
    // hash core and output

    msgSchedule schedule (
        .clk(clk), .resetSHA(resetSHA), .blockIn(block), .blockReady(blockReady),
        .nextWord(nextWord), .schedWord(schedWord)
    );

    compressRound rounds (
        .clk(clk), .resetSHA(resetSHA), .blockReady(blockReady),
        .hashWord(hashWord), .hashIndex(hashIndex), .hashValid(hashValid),
        .kAddress(kAddress), .kEnable(kEnable), .kData(kData),
        .nextWord(nextWord), .schedWord(schedWord),
        .digestOut(digest), .digestValid(digestValid)
    );

    digestWriter writer (
        .clk(clk), .resetSHA(resetSHA), .digestIn(digest), .digestValid(digestValid),
        .domAddress(domAddress), .domData(domData), .domWrite(domWrite),
        .finish(finish)
    );

endmodule

// ==== sim/shaTb.sv ====
/*
 * SHA-256 hasher testbench
 * memory models, fixed vectors from the stim file, digest checks and watchdog
 */
module shaTb;
    timeunit 1ns;
    timeprecision 100ps;

    import shaPkg::*;

    localparam int MaxMsgBytes = 55;
    localparam int MsgLenW     = $clog2(MaxMsgBytes + 1);
    localparam int MsgAddrW    = $clog2(MaxMsgBytes);
    localparam int NumRecords  = 3;
    localparam int MsgWords    = 14;                     // 55 bytes packed four to a word
    localparam int RecordWords = 1 + MsgWords + NumHashWords;
    localparam int RecordBase  = NumRounds + NumHashWords;
    localparam int StimWords   = RecordBase + NumRecords * RecordWords;
    localparam int NumRuns     = NumRecords + 2;         // plus the back to back pair
    localparam int WatchCycles = NumRuns * 400 + 50;

    logic                            clk;
    logic                            resetSHA;
    logic                            go;
    logic [MsgLenW-1:0]              msgLength;
    logic [MsgAddrW-1:0]             msgAddress;
    logic                            msgEnable;
    logic [7:0]                      msgData;
    logic [$clog2(NumHashWords)-1:0] hAddress;
    logic                            hEnable;
    logic [31:0]                     hData;
    logic [$clog2(NumRounds)-1:0]    kAddress;
    logic                            kEnable;
    logic [31:0]                     kData;
    logic [$clog2(NumHashWords)-1:0] domAddress;
    logic [31:0]                     domData;
    logic                            domWrite;
    logic                            finish;

    logic [31:0] stim [StimWords];
    logic [7:0]  msgMem [2**MsgAddrW];
    logic [31:0] hMem [NumHashWords];
    logic [31:0] kMem [NumRounds];
    logic [31:0] domMem [NumHashWords];
    int          writeCount;
    int          finishCount;

    shaTop #(.MaxMsgBytes(MaxMsgBytes)) uut (
        .clk(clk), .resetSHA(resetSHA), .go(go), .msgLength(msgLength),
        .msgAddress(msgAddress), .msgEnable(msgEnable), .msgData(msgData),
        .hAddress(hAddress), .hEnable(hEnable), .hData(hData),
        .kAddress(kAddress), .kEnable(kEnable), .kData(kData),
        .domAddress(domAddress), .domData(domData), .domWrite(domWrite),
        .finish(finish)
    );

    always #20 clk = ~clk;

    // ----------------------------------------
    // memory models, one cycle read latency

    always @(posedge clk) begin
        if (msgEnable)
            msgData <= #2 msgMem[msgAddress];
        if (hEnable)
            hData <= #2 hMem[hAddress];
        if (kEnable)
            kData <= #2 kMem[kAddress];
    end

    always @(negedge clk) begin
        if (domWrite) begin
            domMem[domAddress] = domData;  // output memory
            writeCount++;
        end
        if (finish)
            finishCount++;
    end

    // ----------------------------------------
    // helpers

    task automatic abortRun();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", testName, expected, actual);
            abortRun();
        end
    endtask

    task automatic runHash(input int rec, input string testName);
        int          base;
        int          len;
        int          i;
        logic [31:0] word;
        base = RecordBase + rec * RecordWords;
        len  = stim[base];
        for (i = 0; i < 2**MsgAddrW; i++) begin
            word = stim[base + 1 + (i % (4 * MsgWords)) / 4];
            msgMem[i] = (i < len) ? word[31 - 8 * (i % 4) -: 8]
                                  : (8'(i) ^ 8'hc5);  // filler past the message
        end
        @(posedge clk);
        #2;
        writeCount  = 0;
        finishCount = 0;
        for (i = 0; i < NumHashWords; i++)
            domMem[i] = 32'hx;
        msgLength = MsgLenW'(len);
        go        = 1'b1;
        @(posedge clk);
        #2;
        go = 1'b0;
        do @(negedge clk); while (!finish);
        repeat (3) @(negedge clk);  // a second finish would show here
        checkValue({testName, " write count"}, 32'd8, writeCount);
        checkValue({testName, " finish pulses"}, 32'd1, finishCount);
        for (i = 0; i < NumHashWords; i++)
            checkValue($sformatf("%s digest word %0d", testName, i),
                       stim[base + 1 + MsgWords + i], domMem[i]);
    endtask

    // ----------------------------------------
    // stimulus

    initial begin
        clk         = 1'b0;
        resetSHA    = 1'b1;
        go          = 1'b0;
        msgLength   = '0;
        msgData     = '0;
        hData       = '0;
        kData       = '0;
        writeCount  = 0;
        finishCount = 0;

        $readmemh("sim/shaStim.txt", stim);
        if ($isunknown(stim[StimWords-1])) begin
            $display("stimulus file sim/shaStim.txt is missing or too short");
            abortRun();
        end
        for (int i = 0; i < NumRounds; i++)
            kMem[i] = stim[i];
        for (int i = 0; i < NumHashWords; i++)
            hMem[i] = stim[NumRounds + i];

        repeat (5) @(posedge clk);
        #2;
        resetSHA = 1'b0;

        // idle, nothing may move before go
        repeat (10) begin
            @(negedge clk);
            checkValue("idle finish", 32'd0, finish);
            checkValue("idle domWrite", 32'd0, domWrite);
            checkValue("idle msgEnable", 32'd0, msgEnable);
            checkValue("idle hEnable", 32'd0, hEnable);
            checkValue("idle kEnable", 32'd0, kEnable);
        end

        runHash(0, "empty message");
        runHash(1, "abc");
        runHash(2, "55 bytes");
        runHash(2, "back to back first");
        runHash(1, "back to back second");

        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        repeat (WatchCycles) @(posedge clk);
        $display("timeout: the DUT did not finish all hashes within %0d cycles", WatchCycles);
        abortRun();
    end

endmodule

// ==== sim/shaStim.txt ====
// SHA-256 stimulus, hex words read in order
// 64 round constants K, 8 initial hash words H, then per test:
// length in bytes, 14 message words (bytes big-endian), 8 expected digest words
// round constants
428a2f98 71374491 b5c0fbcf e9b5dba5 3956c25b 59f111f1 923f82a4 ab1c5ed5
d807aa98 12835b01 243185be 550c7dc3 72be5d74 80deb1fe 9bdc06a7 c19bf174
e49b69c1 efbe4786 0fc19dc6 240ca1cc 2de92c6f 4a7484aa 5cb0a9dc 76f988da
983e5152 a831c66d b00327c8 bf597fc7 c6e00bf3 d5a79147 06ca6351 14292967
27b70a85 2e1b2138 4d2c6dfc 53380d13 650a7354 766a0abb 81c2c92e 92722c85
a2bfe8a1 a81a664b c24b8b70 c76c51a3 d192e819 d6990624 f40e3585 106aa070
19a4c116 1e376c08 2748774c 34b0bcb5 391c0cb3 4ed8aa4a 5b9cca4f 682e6ff3
748f82ee 78a5636f 84c87814 8cc70208 90befffa a4506ceb bef9a3f7 c67178f2
// initial hash
6a09e667 bb67ae85 3c6ef372 a54ff53a 510e527f 9b05688c 1f83d9ab 5be0cd19
// test 0, empty message
00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000
e3b0c442 98fc1c14 9afbf4c8 996fb924 27ae41e4 649b934c a495991b 7852b855
// test 1, "abc"
00000003
61626300 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000
ba7816bf 8f01cfea 414140de 5dae2223 b00361a3 96177a9c b410ff61 f20015ad
// test 2, 55 bytes of "a"
00000037
61616161 61616161 61616161 61616161
61616161 61616161 61616161 61616161
61616161 61616161 61616161 61616161
61616161 61616100
9f4390f8 d30c2dd9 2ec9f095 b65e2b9a e9b0a925 a5258e24 1c9f1e91 0f734318

// ==== shaProject.f ====
common/shaPkg.sv
loader/memFetch.sv
loader/padBlock.sv
rounds/msgSchedule.sv
rounds/compressRound.sv
source/digestWriter.sv
source/shaTop.sv
sim/shaTb.sv
